// File: apbi2c.f
hw/i2cPkg.sv
hw/fifoIf.sv
hw/syncFifo.sv
hw/apbRegs.sv
hw/i2cMaster.sv
hw/apbi2cTop.sv
sim/apbi2cBus_chk.sv
sim/i2cTargetModel.sv
sim/apbi2cTb.sv

// File: hw/apbRegs.sv
// Zero-wait APB slave for the bridge with FIFO strobes, config and timeout regs and sticky error
`timescale 1ns/1ps

module apbRegs import i2cPkg::*; (
	input logic PCLK,
	input logic PRESETn,
	input logic PSELx,
	input logic PWRITE,
	input logic PENABLE,
	input logic [31:0] PADDR,
	input logic [31:0] PWDATA,
	output logic [31:0] PRDATA,
	output logic PREADY,
	output logic PSLVERR,
	output logic intTx,
	output logic intRx,
	output logic [CfgWidth-1:0] cfgReg,
	output logic [CfgWidth-1:0] timeoutReg,
	input logic busy,
	input logic errSet,
	fifoIf.writer txQ,
	fifoIf.reader rxQ
);

	//////////////////////////////////////////////////////////////////////
	// Access phase decode
	//////////////////////////////////////////////////////////////////////

	logic access;
	logic mapped;
	logic wrTx;
	logic rdRx;
	logic wrCfg;
	logic wrTimeout;
	logic stickyErr;

	// Every access phase completes at once
	assign access = PSELx && PENABLE;
	assign PREADY = access;

	assign mapped = (PADDR == RegTxData) || (PADDR == RegRxData)
		|| (PADDR == RegConfig) || (PADDR == RegTimeout);

	assign wrTx = access && PWRITE && (PADDR == RegTxData);
	assign rdRx = access && !PWRITE && (PADDR == RegRxData);
	assign wrCfg = access && PWRITE && (PADDR == RegConfig);
	assign wrTimeout = access && PWRITE && (PADDR == RegTimeout);

	// Error response
	// Full TX on push or empty RX on pop is refused here, the FIFOs never see it
	assign PSLVERR = access && (stickyErr || !mapped
		|| (wrTx && txQ.full) || (rdRx && rxQ.empty));

	//////////////////////////////////////////////////////////////////////
	// FIFO strobes
	//////////////////////////////////////////////////////////////////////

	// Push on the access edge of a clean TX write
	assign txQ.push = wrTx && !PSLVERR;
	assign txQ.pushData = i2cTxWord'(PWDATA[15:0]);

	// Head byte is already on popData, pop on the access edge
	assign rxQ.pop = rdRx && !PSLVERR;

	// Interrupts
	assign intTx = txQ.empty && !busy;
	assign intRx = !rxQ.empty;

	//////////////////////////////////////////////////////////////////////
	// Control registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			cfgReg <= '0;
			timeoutReg <= '0;
			stickyErr <= 1'b0;
		end
		else
		begin
			// Registers only change on an error-free transfer
			if (wrCfg && !PSLVERR)
			begin
				cfgReg <= PWDATA[CfgWidth-1:0];
			end
			if (wrTimeout && !PSLVERR)
			begin
				timeoutReg <= PWDATA[CfgWidth-1:0];
			end
			// New engine error wins over a clearing write in the same cycle
			if (errSet)
			begin
				stickyErr <= 1'b1;
			end
			else if (wrCfg)
			begin
				stickyErr <= 1'b0;
			end
		end
	end

	// Read mux
	always_comb
	begin
		case (PADDR)
			RegRxData: PRDATA = {24'd0, rxQ.popData};
			RegConfig: PRDATA = {{(32 - CfgWidth){1'b0}}, cfgReg};
			RegTimeout: PRDATA = {{(32 - CfgWidth){1'b0}}, timeoutReg};
			default: PRDATA = 32'd0;
		endcase
	end

endmodule

// File: hw/apbi2cTop.sv
// Top of the APB to I2C bridge joining the register block, TX and RX FIFOs and the master engine
`timescale 1ns/1ps

module apbi2cTop import i2cPkg::*; #(
	parameter int FifoDepth = 4
) (
	// APB slave
	input logic PCLK,
	input logic PRESETn,
	input logic PSELx,
	input logic PWRITE,
	input logic PENABLE,
	input logic [31:0] PADDR,
	input logic [31:0] PWDATA,
	output logic [31:0] PRDATA,
	output logic PREADY,
	output logic PSLVERR,
	// Interrupts
	output logic intTx,
	output logic intRx,
	// Open-drain I2C, high enables pull the line low
	output logic sclOe,
	output logic sdaOe,
	input logic sclIn,
	input logic sdaIn
);

	//////////////////////////////////////////////////////////////////////
	// Internal links
	//////////////////////////////////////////////////////////////////////

	logic [CfgWidth-1:0] cfgReg;
	logic [CfgWidth-1:0] timeoutReg;
	logic busy;
	logic errSet;

	// TX words toward the engine, RX bytes back
	fifoIf #(.T(i2cTxWord)) txQ();
	fifoIf #(.T(logic [7:0])) rxQ();

	apbRegs uRegs (
		.PCLK, .PRESETn, .PSELx, .PWRITE, .PENABLE, .PADDR, .PWDATA,
		.PRDATA, .PREADY, .PSLVERR, .intTx, .intRx,
		.cfgReg, .timeoutReg, .busy, .errSet,
		.txQ(txQ.writer),
		.rxQ(rxQ.reader)
	);

	syncFifo #(.T(i2cTxWord), .FifoDepth(FifoDepth)) uTxFifo (
		.PCLK, .PRESETn, .q(txQ.store)
	);

	syncFifo #(.T(logic [7:0]), .FifoDepth(FifoDepth)) uRxFifo (
		.PCLK, .PRESETn, .q(rxQ.store)
	);

	// Engine
	i2cMaster uMaster (
		.PCLK, .PRESETn, .cfgReg, .timeoutReg,
		.txQ(txQ.reader),
		.rxQ(rxQ.writer),
		.sclOe, .sdaOe, .busy, .errSet, .sclIn, .sdaIn
	);

endmodule

// File: hw/fifoIf.sv
// Strobe-based FIFO link between a store and its writer and reader, payload type set per instance
`timescale 1ns/1ps

interface fifoIf #(
	parameter type T = logic [7:0]
);

	// Writer side
	logic push;
	T pushData;
	// Reader side
	logic pop;
	T popData;
	// Occupancy flags from the store
	logic empty;
	logic full;

	// Writer also sees empty, the register block builds its TX interrupt from it
	modport writer(output push, output pushData, input full, input empty);
	modport store(input push, input pushData, input pop,
		output popData, output empty, output full);
	modport reader(output pop, input popData, input empty);

endinterface

// File: hw/i2cMaster.sv
// Single-byte I2C master engine taking TX words and returning read bytes, with stretch timeout
`timescale 1ns/1ps

module i2cMaster import i2cPkg::*; (
	input logic PCLK,
	input logic PRESETn,
	input logic [CfgWidth-1:0] cfgReg,
	input logic [CfgWidth-1:0] timeoutReg,
	fifoIf.reader txQ,
	fifoIf.writer rxQ,
	output logic sclOe,
	output logic sdaOe,
	output logic busy,
	output logic errSet,
	input logic sclIn,
	input logic sdaIn
);

	localparam int DivWidth = CfgDivMsb - CfgDivLsb + 1;

	i2cState state;
	// Current transaction and shifter
	i2cTxWord word;
	logic [7:0] shiftReg;
	// Half-period countdown
	logic [DivWidth-1:0] divVal;
	logic [DivWidth-1:0] halfCnt;
	// Bits left in a byte, in stop it marks the first high half
	logic [3:0] bitCnt;
	logic [CfgWidth-1:0] stretchCnt;
	// SCL released by us
	logic sclHigh;
	// Read byte waiting for the end of STOP
	logic rdPend;

	logic enable;
	logic halfDone;
	logic firstLow;
	logic stretchOut;
	logic startReq;
	logic sampleEdge;
	logic stopDone;
	logic sdaNext;

	//////////////////////////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////////////////////////

	assign enable = cfgReg[CfgEnableBit];
	// Two cycles minimum so SDA moves strictly inside the SCL low half
	assign divVal = (cfgReg[CfgDivMsb:CfgDivLsb] < 2) ?
		DivWidth'(2) : cfgReg[CfgDivMsb:CfgDivLsb];

	assign halfDone = (halfCnt == '0);
	assign firstLow = !sclHigh && (halfCnt == divVal - 1'b1);
	// Zero timeout means wait forever
	assign stretchOut = sclHigh && !sclIn && (timeoutReg != '0)
		&& (stretchCnt == timeoutReg);

	// Idle bus and a word queued
	assign startReq = (state == idle) && enable && !txQ.empty && sclIn && sdaIn;
	assign txQ.pop = startReq;

	// End of an SCL high half with the line really high
	assign sampleEdge = busy && (state != stop) && sclHigh && sclIn && halfDone;
	assign stopDone = (state == stop) && sclHigh && sclIn && halfDone && (bitCnt == '0);

	// Read data lands as busy falls
	assign rxQ.push = stopDone && rdPend && !rxQ.full;
	assign rxQ.pushData = shiftReg;

	assign busy = (state != idle);

	// SDA pull for the coming low half
	always_comb
	begin
		case (state)
			addrBits: sdaNext = !shiftReg[7];
			dataBits: sdaNext = !word.rd && !shiftReg[7];
			// Low before SCL rises, then released for STOP
			stop: sdaNext = 1'b1;
			// ACK slots and read bits leave SDA to the target
			default: sdaNext = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Bus sequencer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			state <= idle;
			sclOe <= 1'b0;
			sdaOe <= 1'b0;
			sclHigh <= 1'b1;
			halfCnt <= '0;
			bitCnt <= '0;
			stretchCnt <= '0;
			rdPend <= 1'b0;
			errSet <= 1'b0;
		end
		else
		begin
			errSet <= 1'b0;
			if (state == idle)
			begin
				// START is SDA falling while SCL is high
				if (startReq)
				begin
					state <= start;
					sdaOe <= 1'b1;
					sclHigh <= 1'b1;
					halfCnt <= divVal - 1'b1;
					rdPend <= 1'b0;
				end
			end
			else if (stretchOut)
			begin
				// Stretch too long
				errSet <= 1'b1;
				rdPend <= 1'b0;
				stretchCnt <= '0;
				if (state == stop)
				begin
					state <= idle;
					sclOe <= 1'b0;
					sdaOe <= 1'b0;
					sclHigh <= 1'b1;
				end
				else
				begin
					state <= stop;
					sclOe <= 1'b1;
					sclHigh <= 1'b0;
					bitCnt <= 4'd1;
					halfCnt <= divVal - 1'b1;
				end
			end
			else if (!sclHigh)
			begin
				// SCL low half
				if (firstLow)
				begin
					sdaOe <= sdaNext;
				end
				if (halfDone)
				begin
					sclOe <= 1'b0;
					sclHigh <= 1'b1;
					halfCnt <= divVal - 1'b1;
					stretchCnt <= '0;
				end
				else
				begin
					halfCnt <= halfCnt - 1'b1;
				end
			end
			else if (!sclIn)
			begin
				// Target holds SCL low
				stretchCnt <= stretchCnt + 1'b1;
			end
			else if (!halfDone)
			begin
				halfCnt <= halfCnt - 1'b1;
			end
			else if (state == stop)
			begin
				if (bitCnt != '0)
				begin
					// STOP, then one more half of bus free time
					sdaOe <= 1'b0;
					bitCnt <= '0;
					halfCnt <= divVal - 1'b1;
				end
				else
				begin
					state <= idle;
					rdPend <= 1'b0;
					// RX overflow drops the byte
					if (rdPend && rxQ.full)
					begin
						errSet <= 1'b1;
					end
				end
			end
			else
			begin
				// Sample point, then SCL falls
				sclOe <= 1'b1;
				sclHigh <= 1'b0;
				halfCnt <= divVal - 1'b1;
				case (state)
					start:
					begin
						state <= addrBits;
						bitCnt <= 4'd7;
					end
					addrBits, dataBits:
					begin
						if (bitCnt == '0)
						begin
							state <= (state == addrBits) ? addrAck : dataAck;
						end
						else
						begin
							bitCnt <= bitCnt - 1'b1;
						end
					end
					addrAck:
					begin
						if (sdaIn)
						begin
							// Address NACK
							errSet <= 1'b1;
							state <= stop;
							bitCnt <= 4'd1;
						end
						else
						begin
							state <= dataBits;
							bitCnt <= 4'd7;
						end
					end
					default:
					begin
						// Data ACK slot, our NACK on reads
						if (!word.rd && sdaIn)
						begin
							errSet <= 1'b1;
						end
						rdPend <= word.rd;
						state <= stop;
						bitCnt <= 4'd1;
					end
				endcase
			end
		end
	end

	// Payload shifter, same shift for write bits and read bits
	always_ff @(posedge PCLK)
	begin
		if (startReq)
		begin
			word <= txQ.popData;
			shiftReg <= {txQ.popData.addr, txQ.popData.rd};
		end
		else if (sampleEdge)
		begin
			if (state == addrAck)
			begin
				shiftReg <= word.data;
			end
			else if (state == addrBits || state == dataBits)
			begin
				shiftReg <= {shiftReg[6:0], sdaIn};
			end
		end
	end

endmodule

// File: hw/i2cPkg.sv
// Register offsets, config fields, TX word layout and engine states shared by the bridge RTL
package i2cPkg;

	//////////////////////////////////////////////////////////////////////
	// APB register map
	//////////////////////////////////////////////////////////////////////

	// TX word port, write only
	localparam logic [31:0] RegTxData = 32'd0;
	// RX byte port, read only
	localparam logic [31:0] RegRxData = 32'd4;
	localparam logic [31:0] RegConfig = 32'd8;
	localparam logic [31:0] RegTimeout = 32'd12;

	// Width of configuration and timeout registers
	localparam int CfgWidth = 14;

	// SCL half-period divider in PCLK cycles
	localparam int CfgDivLsb = 0;
	localparam int CfgDivMsb = 9;
	// Engine enable
	localparam int CfgEnableBit = 13;

	// One I2C transaction per TX word
	// Sits in PWDATA[15:0] with data in the low byte
	typedef struct packed {
		logic rd;
		logic [6:0] addr;
		logic [7:0] data;
	} i2cTxWord;

	// Master engine sequence
	typedef enum logic [2:0] {
		idle, start, addrBits, addrAck, dataBits, dataAck, stop
	} i2cState;

endpackage

// File: hw/syncFifo.sv
// Show-ahead single-clock FIFO used for both the TX word queue and the RX byte queue
`timescale 1ns/1ps

module syncFifo #(
	parameter type T = logic [7:0],
	// Power of two, at least 2
	parameter int FifoDepth = 4
) (
	input logic PCLK,
	input logic PRESETn,
	fifoIf.store q
);

	localparam int PtrWidth = $clog2(FifoDepth);

	//////////////////////////////////////////////////////////////////////
	// Storage and pointers
	//////////////////////////////////////////////////////////////////////

	T mem [FifoDepth];

	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	// One bit wider than the pointers to tell full from empty
	logic [PtrWidth:0] count;

	// Pointer and count update
	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			// Pointers wrap on their own at a power-of-two depth
			if (q.push)
			begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (q.pop)
			begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({q.push, q.pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Payload write
	always_ff @(posedge PCLK)
	begin
		if (q.push)
		begin
			mem[wrPtr] <= q.pushData;
		end
	end

	// Head is always presented
	assign q.popData = mem[rdPtr];

	// Flags straight from the count
	assign q.empty = (count == '0);
	assign q.full = (count == (PtrWidth + 1)'(FifoDepth));

endmodule

// File: sim/apbi2cBus_chk.sv
// APB and I2C protocol assertions, bound into the bridge top level by the testbench
`timescale 1ns/1ps

module apbi2cBus_chk import i2cPkg::*; (
	input logic PCLK,
	input logic PRESETn,
	input logic PSELx,
	input logic PENABLE,
	input logic PREADY,
	input logic PSLVERR,
	input logic intTx,
	input logic busy,
	input logic sclIn,
	input logic sdaIn,
	input i2cState engState
);

	// Failed assertions so far
	int assertFails = 0;

	//////////////////////////////////////////////////////////////////////
	// APB side
	//////////////////////////////////////////////////////////////////////

	// Zero wait states
	accessReady: assert property (@(posedge PCLK) disable iff (!PRESETn)
		PSELx && PENABLE |-> PREADY)
		else
		begin
			$error("PREADY low during an APB access phase");
			assertFails++;
		end

	// Error response only inside an access phase
	errInAccess: assert property (@(posedge PCLK) disable iff (!PRESETn)
		!(PSELx && PENABLE) |-> !PSLVERR)
		else
		begin
			$error("PSLVERR high outside an APB access phase");
			assertFails++;
		end

	// TX interrupt waits for the engine
	txIntIdle: assert property (@(posedge PCLK) disable iff (!PRESETn)
		intTx |-> !busy)
		else
		begin
			$error("intTx high while the engine is busy");
			assertFails++;
		end

	//////////////////////////////////////////////////////////////////////
	// I2C side
	//////////////////////////////////////////////////////////////////////

	// SDA moves under high SCL only for START or STOP
	sdaWhileSclHigh: assert property (@(posedge PCLK) disable iff (!PRESETn)
		$changed(sdaIn) && sclIn && $past(sclIn) |->
		($fell(sdaIn) && engState == start)
		|| ($rose(sdaIn) && (engState == stop || engState == idle)))
		else
		begin
			$error("SDA changed while SCL was high outside START or STOP");
			assertFails++;
		end

endmodule

// File: sim/apbi2cTb.sv
// Testbench for the APB to I2C bridge, runs a stimulus table against a behavioural I2C target
`timescale 1ns/1ps

module apbi2cTb import i2cPkg::*; ();

	typedef enum int {cfgRw, tmoRw, i2cWr, i2cRd, rxEmpty, badAddr} rowKind;
	// I2C rows use expected as the error flag, register rows as the readback
	typedef struct {
		rowKind kind;
		logic [31:0] addr;
		logic [31:0] data;
		int stretch;
		logic [31:0] expected;
	} testRow;

	localparam int NumRows = 11;
	localparam int WaitLimit = 3000;

	logic PCLK;
	logic PRESETn;
	logic PSELx;
	logic PWRITE;
	logic PENABLE;
	logic [31:0] PADDR;
	logic [31:0] PWDATA;
	logic [31:0] PRDATA;
	logic PREADY;
	logic PSLVERR;
	logic intTx;
	logic intRx;
	logic sclOe;
	logic sdaOe;
	logic sclIn;
	logic sdaIn;
	logic tgtSclLow;
	logic tgtSdaLow;
	logic [7:0] tgtReg;
	int stretchLen;

	testRow rows [NumRows];
	int errCount;
	int passCount;
	logic [31:0] rngState;
	logic [31:0] cfgShadow;
	logic [7:0] tgtShadow;

	// Open-drain lines with pull-ups, any pull-low wins
	assign sclIn = !(sclOe || tgtSclLow);
	assign sdaIn = !(sdaOe || tgtSdaLow);

	apbi2cTop #(.FifoDepth(4)) u_dut (
		.PCLK, .PRESETn, .PSELx, .PWRITE, .PENABLE, .PADDR, .PWDATA,
		.PRDATA, .PREADY, .PSLVERR, .intTx, .intRx,
		.sclOe, .sdaOe, .sclIn, .sdaIn
	);

	i2cTargetModel #(.Addr(7'h2A)) uTarget (
		.PCLK, .PRESETn, .scl(sclIn), .sda(sdaIn), .stretchLen,
		.sclLow(tgtSclLow), .sdaLow(tgtSdaLow), .regByte(tgtReg)
	);

	bind apbi2cTop apbi2cBus_chk uBusChk (
		.PCLK(PCLK), .PRESETn(PRESETn), .PSELx(PSELx), .PENABLE(PENABLE),
		.PREADY(PREADY), .PSLVERR(PSLVERR), .intTx(intTx), .busy(busy),
		.sclIn(sclIn), .sdaIn(sdaIn), .engState(uMaster.state)
	);

	initial
	begin
		PCLK = 1'b0;
		forever #5 PCLK = ~PCLK;
	end

	// Run limit from the table length
	initial
	begin
		repeat (NumRows * 4000) @(posedge PCLK);
		$display("Watchdog expired after %0d cycles with rows still running", NumRows * 4000);
		$display("tests failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic checkVal(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
		begin
			$display("ERR %0t: %s, got %h expected %h", $time, what, got, exp);
			errCount++;
		end
	endtask

	// Setup and access phases 1 ns after the edge, outputs sampled mid access phase
	task automatic apbWrite(input logic [31:0] addr, input logic [31:0] data, output logic err);
		@(posedge PCLK);
		#1;
		PSELx = 1'b1;
		PWRITE = 1'b1;
		PADDR = addr;
		PWDATA = data;
		@(posedge PCLK);
		#1;
		PENABLE = 1'b1;
		#4;
		err = PSLVERR;
		@(posedge PCLK);
		#1;
		PSELx = 1'b0;
		PENABLE = 1'b0;
	endtask

	task automatic apbRead(input logic [31:0] addr, output logic [31:0] data, output logic err);
		@(posedge PCLK);
		#1;
		PSELx = 1'b1;
		PWRITE = 1'b0;
		PADDR = addr;
		@(posedge PCLK);
		#1;
		PENABLE = 1'b1;
		#4;
		data = PRDATA;
		err = PSLVERR;
		@(posedge PCLK);
		#1;
		PSELx = 1'b0;
		PENABLE = 1'b0;
	endtask

	task automatic waitBusy(input logic level);
		int n;
		logic seen;
		seen = 1'b0;
		for (n = 0; n < WaitLimit && !seen; n++)
		begin
			@(negedge PCLK);
			seen = (u_dut.busy === level);
		end
		if (!seen)
		begin
			$display("Engine busy flag did not go to %0b within %0d cycles", level, WaitLimit);
			errCount++;
		end
	endtask

	// One I2C transaction, then error status and data checks
	task automatic runTransfer(input testRow r);
		i2cTxWord word;
		logic [31:0] rdData;
		logic err;
		logic clrErr;
		rngState = xorshift(rngState);
		word.rd = (r.kind == i2cRd);
		word.addr = r.addr[6:0];
		word.data = word.rd ? 8'h00 : rngState[7:0];
		stretchLen = r.stretch;
		apbWrite(RegTxData, {16'h0000, word}, err);
		checkVal(err, 0, "PSLVERR on TX push");
		waitBusy(1'b1);
		waitBusy(1'b0);
		checkVal(intTx, 1, "intTx after transaction");
		checkVal(intRx, word.rd && !r.expected[0], "intRx after transaction");
		// Sticky error shows on the next access, config write clears it
		apbRead(RegConfig, rdData, err);
		checkVal(err, r.expected, "error status after transaction");
		if (err)
		begin
			apbWrite(RegConfig, cfgShadow, clrErr);
			apbRead(RegConfig, rdData, err);
			checkVal(err, 0, "PSLVERR after clearing write");
		end
		if (!r.expected[0] && !word.rd)
		begin
			tgtShadow = word.data;
			checkVal(tgtReg, tgtShadow, "target register after write");
		end
		if (!r.expected[0] && word.rd)
		begin
			apbRead(RegRxData, rdData, err);
			checkVal(err, 0, "PSLVERR on RX pop");
			checkVal(rdData, {24'h0, tgtShadow}, "RX byte");
			@(negedge PCLK);
			checkVal(intRx, 0, "intRx after pop");
		end
	endtask

	task automatic runRow(input testRow r);
		logic [31:0] rdData;
		logic err;
		case (r.kind)
			cfgRw, tmoRw:
			begin
				apbWrite(r.addr, r.data, err);
				checkVal(err, 0, "PSLVERR on register write");
				apbRead(r.addr, rdData, err);
				checkVal(err, 0, "PSLVERR on register read");
				checkVal(rdData, r.expected, "register readback");
				if (r.kind == cfgRw)
				begin
					cfgShadow = r.data;
				end
			end
			i2cWr, i2cRd:
			begin
				runTransfer(r);
			end
			default:
			begin
				apbRead(r.addr, rdData, err);
				checkVal(err, r.expected, "PSLVERR on refused read");
				if (r.kind == badAddr)
				begin
					apbWrite(r.addr, 32'h0, err);
					checkVal(err, r.expected, "PSLVERR on unmapped write");
				end
			end
		endcase
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus table and main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		PRESETn = 1'b0;
		PSELx = 1'b0;
		PWRITE = 1'b0;
		PENABLE = 1'b0;
		PADDR = '0;
		PWDATA = '0;
		stretchLen = 0;
		errCount = 0;
		passCount = 0;
		rngState = 32'h51af;
		cfgShadow = '0;
		tgtShadow = 8'h00;
		// Reserved bits read as written, then enable with divider 4
		rows[0] = '{cfgRw, RegConfig, 32'h1C07, 0, 32'h1C07};
		rows[1] = '{tmoRw, RegTimeout, 32'd50, 0, 32'd50};
		rows[2] = '{cfgRw, RegConfig, 32'h2004, 0, 32'h2004};
		rows[3] = '{i2cWr, 32'h2A, 32'h0, 0, 32'd0};
		rows[4] = '{i2cRd, 32'h2A, 32'h0, 0, 32'd0};
		// Nobody answers at 7'h31
		rows[5] = '{i2cWr, 32'h31, 32'h0, 0, 32'd1};
		rows[6] = '{i2cWr, 32'h2A, 32'h0, 20, 32'd0};
		rows[7] = '{i2cRd, 32'h2A, 32'h0, 20, 32'd0};
		// Stretch well past the timeout of 50
		rows[8] = '{i2cWr, 32'h2A, 32'h0, 200, 32'd1};
		rows[9] = '{rxEmpty, RegRxData, 32'h0, 0, 32'd1};
		rows[10] = '{badAddr, 32'h10, 32'h0, 0, 32'd1};
		repeat (16) @(posedge PCLK);
		#1;
		PRESETn = 1'b1;
		@(negedge PCLK);
		checkVal(intTx, 1, "intTx after reset");
		checkVal(intRx, 0, "intRx after reset");
		checkVal({sclOe, sdaOe, PSLVERR}, 0, "bus enables and PSLVERR after reset");
		for (int i = 0; i < NumRows; i++)
		begin
			int errBefore;
			errBefore = errCount;
			runRow(rows[i]);
			if (errCount == errBefore)
			begin
				passCount++;
				$display("Row %0d %s: ok", i, rows[i].kind.name());
			end
			else
			begin
				$display("Row %0d %s: FAIL", i, rows[i].kind.name());
			end
		end
		errCount += u_dut.uBusChk.assertFails;
		$display("%0d of %0d rows ok, %0d mismatches", passCount, NumRows, errCount);
		if (errCount == 0)
		begin
			$display("all tests passed");
		end
		else
		begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: sim/i2cTargetModel.sv
// Behavioural I2C target for the bridge testbench, one address, one byte register, SCL stretch
`timescale 1ns/1ps

module i2cTargetModel #(
	parameter logic [6:0] Addr = 7'h2A
) (
	input logic PCLK,
	input logic PRESETn,
	input logic scl,
	input logic sda,
	// PCLK cycles to hold SCL low after the address ACK, zero for none
	input int stretchLen,
	output logic sclLow,
	output logic sdaLow,
	output logic [7:0] regByte
);

	typedef enum logic [2:0] {
		tIdle, tAddr, tAddrAck, tWrite, tWriteAck, tRead, tReadAck
	} tgtState;

	tgtState state;
	logic prevScl;
	logic prevSda;
	logic [7:0] shiftIn;
	logic [3:0] bitCnt;
	logic isRead;
	int holdCnt;

	// Bus sampled on PCLK, so every reaction lands one cycle after the edge it follows
	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			state <= tIdle;
			prevScl <= 1'b1;
			prevSda <= 1'b1;
			shiftIn <= '0;
			bitCnt <= '0;
			isRead <= 1'b0;
			holdCnt <= 0;
			sclLow <= 1'b0;
			sdaLow <= 1'b0;
			regByte <= 8'h00;
		end
		else
		begin
			prevScl <= scl;
			prevSda <= sda;
			// Stretch countdown
			if (holdCnt > 1)
			begin
				holdCnt <= holdCnt - 1;
			end
			else if (holdCnt == 1)
			begin
				holdCnt <= 0;
				sclLow <= 1'b0;
			end
			if (prevScl && scl && prevSda && !sda)
			begin
				// START restarts the model from any state
				state <= tAddr;
				bitCnt <= '0;
				sdaLow <= 1'b0;
			end
			else if (prevScl && scl && !prevSda && sda)
			begin
				// STOP
				state <= tIdle;
				sdaLow <= 1'b0;
			end
			else if (!prevScl && scl)
			begin
				// Rising SCL, take a bit
				if (state == tAddr || state == tWrite)
				begin
					shiftIn <= {shiftIn[6:0], sda};
					bitCnt <= bitCnt + 1'b1;
				end
			end
			else if (prevScl && !scl)
			begin
				// Falling SCL, set up the next bit
				case (state)
					tAddr:
					begin
						if (bitCnt == 4'd8 && shiftIn[7:1] == Addr)
						begin
							sdaLow <= 1'b1;
							isRead <= shiftIn[0];
							state <= tAddrAck;
						end
						else if (bitCnt == 4'd8)
						begin
							// Not ours, stay off the bus
							state <= tIdle;
						end
					end
					tAddrAck:
					begin
						if (stretchLen > 0)
						begin
							sclLow <= 1'b1;
							holdCnt <= stretchLen;
						end
						// First read bit replaces the ACK at once
						sdaLow <= isRead ? !regByte[7] : 1'b0;
						bitCnt <= isRead ? 4'd1 : 4'd0;
						state <= isRead ? tRead : tWrite;
					end
					tWrite:
					begin
						if (bitCnt == 4'd8)
						begin
							regByte <= shiftIn;
							sdaLow <= 1'b1;
							state <= tWriteAck;
						end
					end
					tRead:
					begin
						if (bitCnt == 4'd8)
						begin
							// Leave SDA free for the master NACK
							sdaLow <= 1'b0;
							state <= tReadAck;
						end
						else
						begin
							sdaLow <= !regByte[7 - bitCnt];
							bitCnt <= bitCnt + 1'b1;
						end
					end
					default:
					begin
						sdaLow <= 1'b0;
						state <= tIdle;
					end
				endcase
			end
		end
	end

endmodule
